// File: all.f
+incdir+common
common/dmc_pkg.sv
common/dfi_cmd_if.sv
logic/dmc_cmd_queue.sv
sequencer/dmc_cmd_sequencer.sv
scheduler/dmc_issue_scheduler.sv
logic/dmc_top.sv
dv/dmc_chk.sv
dv/dmc_tb.sv

// File: common/dfi_cmd_if.sv
`timescale 1ns/10ps

interface dfi_cmd_if;

  logic                    valid;
  logic                    ready;
  dmc_pkg::dfi_cmd_entry_s entry;

  // the source raises valid only while ready is already high
  modport src (
    output valid,
    output entry,
    input  ready
  );

  modport dst (
    input  valid,
    input  entry,
    output ready
  );

endinterface

// File: common/dmc_pkg.sv
`include "dmc_settings.svh"

package dmc_pkg;

  // bit 0 selects a read and bit 1 asks for auto-precharge
  typedef enum logic [2:0] {
    WR = 3'b000,
    RD = 3'b001,
    WP = 3'b010,
    RP = 3'b011
  } app_cmd_e;

  // each value is the {cs_n, ras_n, cas_n, we_n} pattern of the command
  typedef enum logic [3:0] {
    LMR      = 4'b0000,
    REF      = 4'b0001,
    PRE      = 4'b0010,
    ACT      = 4'b0011,
    WRITE    = 4'b0100,
    READ     = 4'b0101,
    NOP      = 4'b0111,
    DESELECT = 4'b1111
  } dfi_cmd_e;

  typedef struct packed {
    logic cs_n;
    logic ras_n;
    logic cas_n;
    logic we_n;
  } dfi_pins_s;

  // one word seen either as the command or as the raw pin levels
  typedef union packed {
    dfi_cmd_e  op;
    dfi_pins_s pins;
  } dfi_cmd_u;

  typedef struct packed {
    dfi_cmd_u                       cmd;
    logic [`DMC_BANK_WIDTH-1:0]     ba;
    logic [`DMC_DFI_ADDR_WIDTH-1:0] addr;
  } dfi_cmd_entry_s;

endpackage

// File: common/dmc_settings.svh
`ifndef DMC_SETTINGS_SVH
`define DMC_SETTINGS_SVH

// user address map from low to high is column, bank, row
`define DMC_ADDR_WIDTH     24
`define DMC_COL_WIDTH      10
`define DMC_BANK_WIDTH     3
`define DMC_ROW_WIDTH      11
`define DMC_COL_POS        0
`define DMC_BANK_POS       (`DMC_COL_POS + `DMC_COL_WIDTH)
`define DMC_ROW_POS        (`DMC_BANK_POS + `DMC_BANK_WIDTH)

`define DMC_DFI_ADDR_WIDTH 16
`define DMC_AP_BIT         10      // A10 selects auto-precharge and precharge-all
`define DMC_QUEUE_DEPTH    4
`define DMC_BURST_CYCLES   4
`define DMC_MR0            16'h0033  // burst of 8 with CAS latency 3

// DDR timings in DFI clock cycles
`define DMC_TMRD           2
`define DMC_TRFC           10
`define DMC_TRP            3
`define DMC_TRAS           8
`define DMC_TRRD           2
`define DMC_TRCD           3
`define DMC_TWR            4
`define DMC_TWTR           2
`define DMC_TRTP           2
`define DMC_TCAS           3
`define DMC_TRC            11

`define DMC_TREFI          200
`define DMC_REFI_WIDTH     16
`define DMC_TICK_WIDTH     8
`define DMC_INIT_CMDS      5

`endif

// File: dv/dmc_chk.sv
`timescale 1ns/10ps
`include "dmc_settings.svh"

module dmc_chk (
  input logic       clk_i,
  input logic       rst_i,
  input logic [3:0] pins_i,  // {cs_n, ras_n, cas_n, we_n}
  input logic       pop_i,
  input logic       empty_i  // the command queue holds no entry
);

  int   fail_count = 0;  // read by the testbench
  logic is_act;
  logic is_col;

  assign is_act = (pins_i == dmc_pkg::ACT);
  assign is_col = (pins_i == dmc_pkg::READ) || (pins_i == dmc_pkg::WRITE);

  // the edge after one that saw reset still shows deselect
  reset_deselect_a: assert property (@(posedge clk_i) rst_i |=> pins_i == dmc_pkg::DESELECT)
    else begin
      fail_count++;
      $error("command pins left deselect while reset was high");
    end

  act_to_col_a: assert property (@(posedge clk_i) disable iff (rst_i)
    is_act |=> !is_col [*(`DMC_TRCD - 1)])
    else begin
      fail_count++;
      $error("column command followed an ACT within tRCD");
    end

  pop_not_empty_a: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_i)
    else begin
      fail_count++;
      $error("scheduler popped while the queue was empty");
    end

endmodule

bind dmc_issue_scheduler dmc_chk u_chk (
  .clk_i   (dfi_clk_i),
  .rst_i   (dfi_clk_sync_rst_i),
  .pins_i  ({dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o}),
  .pop_i   (pop),
  .empty_i (u_queue.count_q == '0)
);

// File: dv/dmc_tb.sv
`timescale 1ns/10ps
`include "dmc_settings.svh"

module dmc_tb;

  localparam int num_req_lp    = 400;
  localparam int wait_limit_lp = 2000;
  localparam int refi_limit_lp = `DMC_TREFI + 100;  // interval plus slack for a busy pipeline
  localparam int num_banks_lp  = 1 << `DMC_BANK_WIDTH;
  localparam logic [`DMC_DFI_ADDR_WIDTH-1:0] pre_all_addr_lp = 1 << `DMC_AP_BIT;

  typedef struct {
    dmc_pkg::dfi_cmd_e              op;
    logic [`DMC_BANK_WIDTH-1:0]     ba;
    logic [`DMC_DFI_ADDR_WIDTH-1:0] addr;
    logic                           chk_ba;
    logic                           chk_addr;
    string                          tag;
  } exp_cmd_s;

  logic                           clk = 1'b0;
  logic                           rst;
  logic                           app_en;
  dmc_pkg::app_cmd_e              app_cmd;
  logic [`DMC_ADDR_WIDTH-1:0]     app_addr;
  logic                           app_rdy, init_done, refresh_busy;
  logic                           dfi_cke, dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n;
  logic [`DMC_BANK_WIDTH-1:0]     dfi_bank;
  logic [`DMC_DFI_ADDR_WIDTH-1:0] dfi_address;

  // reference model state
  exp_cmd_s                  exp_q[$];
  logic                      open_bank [num_banks_lp];
  logic [`DMC_ROW_WIDTH-1:0] open_row [num_banks_lp];
  int                        refresh_count;
  int                        since_refresh;

  // spacing trackers, in negedge cycles
  int                         cyc;
  int                         last_cmd_cyc, last_act_cyc, last_wr_cyc, last_rd_cyc, last_col_cyc;
  dmc_pkg::dfi_cmd_e          last_op;
  logic [`DMC_BANK_WIDTH-1:0] last_act_ba;
  logic                       last_col_ap, last_col_wr;

  logic [31:0] lfsr_q = 32'h7ead;

  dmc_top DUT (
    .dfi_clk_i             (clk),
    .dfi_clk_sync_rst_i    (rst),
    .app_en_i              (app_en),
    .app_cmd_i             (app_cmd),
    .app_addr_i            (app_addr),
    .app_rdy_o             (app_rdy),
    .init_calib_complete_o (init_done),
    .refresh_in_progress_o (refresh_busy),
    .dfi_cke_o             (dfi_cke),
    .dfi_cs_n_o            (dfi_cs_n),
    .dfi_ras_n_o           (dfi_ras_n),
    .dfi_cas_n_o           (dfi_cas_n),
    .dfi_we_n_o            (dfi_we_n),
    .dfi_bank_o            (dfi_bank),
    .dfi_address_o         (dfi_address)
  );

  always #5 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1, stepped once for every bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // failure and compare tasks

  task automatic end_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_op(input string name, input dmc_pkg::dfi_cmd_e exp,
                          input dmc_pkg::dfi_cmd_e act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %s (%b) actual %s (%b)", name, exp.name(), exp,
               act.name(), act);
      end_with_failure();
    end
  endtask

  task automatic check_bank(input string name, input logic [`DMC_BANK_WIDTH-1:0] exp,
                            input logic [`DMC_BANK_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [`DMC_DFI_ADDR_WIDTH-1:0] exp,
                            input logic [`DMC_DFI_ADDR_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_gap(input string name, input int min_gap, input int act);
    if (act < min_gap) begin
      $display("[FAIL] spacing %s expected at least %0d actual %0d", name, min_gap, act);
      end_with_failure();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model

  task automatic expect_cmd(input dmc_pkg::dfi_cmd_e op, input logic [`DMC_BANK_WIDTH-1:0] ba,
                            input logic [`DMC_DFI_ADDR_WIDTH-1:0] addr, input logic chk_ba,
                            input logic chk_addr, input string tag);
    exp_cmd_s e;
    e.op       = op;
    e.ba       = ba;
    e.addr     = addr;
    e.chk_ba   = chk_ba;
    e.chk_addr = chk_addr;
    e.tag      = tag;
    exp_q.push_back(e);
  endtask

  task automatic model_request(input dmc_pkg::app_cmd_e cmd,
                               input logic [`DMC_ADDR_WIDTH-1:0] addr);
    logic [`DMC_COL_WIDTH-1:0]      col;
    logic [`DMC_BANK_WIDTH-1:0]     ba;
    logic [`DMC_ROW_WIDTH-1:0]      row;
    logic [`DMC_DFI_ADDR_WIDTH-1:0] col_addr;
    logic                           hit;
    col = addr[`DMC_COL_POS +: `DMC_COL_WIDTH];
    ba  = addr[`DMC_BANK_POS +: `DMC_BANK_WIDTH];
    row = addr[`DMC_ROW_POS +: `DMC_ROW_WIDTH];
    hit = open_bank[ba] && (open_row[ba] == row);
    if (open_bank[ba] && !hit) expect_cmd(dmc_pkg::PRE, ba, '0, 1'b1, 1'b1, "conflict PRE");
    if (!hit) begin
      expect_cmd(dmc_pkg::ACT, ba, `DMC_DFI_ADDR_WIDTH'(row), 1'b1, 1'b1, "page ACT");
    end
    col_addr = `DMC_DFI_ADDR_WIDTH'(col);
    col_addr[`DMC_AP_BIT] = cmd[1];  // bit 1 of the user command asks for auto-precharge
    expect_cmd(cmd[0] ? dmc_pkg::READ : dmc_pkg::WRITE, ba, col_addr, 1'b1, 1'b1, "column");
    open_bank[ba] = !cmd[1];
    open_row[ba]  = row;
  endtask

  task automatic model_refresh();
    logic any_open;
    any_open = 1'b0;
    for (int i = 0; i < num_banks_lp; i++) begin
      any_open |= open_bank[i];
      open_bank[i] = 1'b0;
    end
    if (any_open) expect_cmd(dmc_pkg::PRE, '0, pre_all_addr_lp, 1'b0, 1'b1, "refresh PRE-all");
    expect_cmd(dmc_pkg::REF, '0, '0, 1'b0, 1'b0, "refresh REF");
    refresh_count++;
    since_refresh = 0;
  endtask

  task automatic check_spacing(input dmc_pkg::dfi_cmd_e op,
                               input logic [`DMC_BANK_WIDTH-1:0] ba, input logic ap);
    int ap_need;
    ap_need = last_col_wr ? `DMC_TWR + `DMC_TRP : `DMC_TRTP + `DMC_TRP;
    case (last_op)
      dmc_pkg::LMR: check_gap("LMR to any", `DMC_TMRD, cyc - last_cmd_cyc);
      dmc_pkg::REF: check_gap("REF to any", `DMC_TRFC, cyc - last_cmd_cyc);
      dmc_pkg::PRE: check_gap("PRE to any", `DMC_TRP, cyc - last_cmd_cyc);
      default: ;
    endcase
    case (op)
      dmc_pkg::PRE: begin
        check_gap("ACT to PRE", `DMC_TRAS, cyc - last_act_cyc);
        check_gap("WRITE to PRE", `DMC_TWR, cyc - last_wr_cyc);
        check_gap("READ to PRE", `DMC_TRTP, cyc - last_rd_cyc);
      end
      dmc_pkg::ACT, dmc_pkg::REF: begin
        if (last_col_ap) check_gap("auto-precharge to ACT or REF", ap_need, cyc - last_col_cyc);
        if (op == dmc_pkg::ACT) begin
          check_gap("ACT to ACT", `DMC_TRRD, cyc - last_act_cyc);
          if (ba == last_act_ba) check_gap("ACT to ACT new row", `DMC_TRC, cyc - last_act_cyc);
        end
      end
      dmc_pkg::READ, dmc_pkg::WRITE: begin
        check_gap("ACT to column", `DMC_TRCD, cyc - last_act_cyc);
        check_gap("column to column", `DMC_BURST_CYCLES, cyc - last_col_cyc);
        if (op == dmc_pkg::WRITE) begin
          check_gap("READ to WRITE", `DMC_TCAS + `DMC_BURST_CYCLES, cyc - last_rd_cyc);
        end else begin
          check_gap("WRITE to READ", `DMC_TWTR, cyc - last_wr_cyc);
        end
      end
      default: ;
    endcase
    last_cmd_cyc = cyc;
    last_op      = op;
    if (op == dmc_pkg::ACT) begin
      last_act_cyc = cyc;
      last_act_ba  = ba;
    end
    if (op == dmc_pkg::READ || op == dmc_pkg::WRITE) begin
      last_col_cyc = cyc;
      last_col_ap  = ap;
      last_col_wr  = (op == dmc_pkg::WRITE);
      if (op == dmc_pkg::WRITE) last_wr_cyc = cyc;
      else                      last_rd_cyc = cyc;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor, sampling at the falling edge

  initial begin : monitor
    dmc_pkg::dfi_cmd_u seen;
    exp_cmd_s          e;
    logic              rst_prev;
    logic              refr_prev;
    rst_prev  = 1'b1;  // the first edge sees reset
    refr_prev = 1'b0;
    forever begin
      @(negedge clk);
      cyc++;
      seen.pins.cs_n  = dfi_cs_n;
      seen.pins.ras_n = dfi_ras_n;
      seen.pins.cas_n = dfi_cas_n;
      seen.pins.we_n  = dfi_we_n;
      if (rst_prev) begin
        check_op("reset pins", dmc_pkg::DESELECT, seen.op);
        check_flag("reset cke", 1'b0, dfi_cke);
        check_flag("reset app_rdy", 1'b0, app_rdy);
        check_flag("reset init_calib_complete", 1'b0, init_done);
        check_flag("reset refresh_in_progress", 1'b0, refresh_busy);
      end else begin
        check_flag("cke after reset", 1'b1, dfi_cke);
      end
      if (DUT.u_scheduler.u_chk.fail_count != 0) begin
        $display("an assertion on the scheduler failed");
        end_with_failure();
      end
      if (app_rdy && !init_done) begin
        $display("app_rdy_o went high before init_calib_complete_o");
        end_with_failure();
      end
      if (init_done) since_refresh++;
      if (since_refresh > refi_limit_lp) begin
        $display("no refresh started within %0d cycles", refi_limit_lp);
        end_with_failure();
      end
      if (refresh_busy && !refr_prev) model_refresh();
      if (app_en && app_rdy) model_request(app_cmd, app_addr);  // taken at the next edge
      if (!rst_prev && seen.op != dmc_pkg::DESELECT) begin
        if (exp_q.size() == 0) begin
          $display("command %b appeared on the pins when none was expected", seen.pins);
          end_with_failure();
        end
        e = exp_q.pop_front();
        check_op({e.tag, " op"}, e.op, seen.op);
        if (e.chk_ba)   check_bank({e.tag, " bank"}, e.ba, dfi_bank);
        if (e.chk_addr) check_addr({e.tag, " address"}, e.addr, dfi_address);
        check_spacing(seen.op, dfi_bank, dfi_address[`DMC_AP_BIT]);
      end
      rst_prev  = rst;
      refr_prev = refresh_busy;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus

  initial begin : stimulus
    dmc_pkg::app_cmd_e          cmd;
    logic [`DMC_ADDR_WIDTH-1:0] addr;
    int                         idle;
    int                         waited;
    rst           = 1'b1;
    app_en        = 1'b0;
    app_cmd       = dmc_pkg::WR;
    app_addr      = '0;
    cyc           = 0;
    refresh_count = 0;
    since_refresh = 0;
    last_cmd_cyc  = -1000;
    last_act_cyc  = -1000;
    last_wr_cyc   = -1000;
    last_rd_cyc   = -1000;
    last_col_cyc  = -1000;
    last_op       = dmc_pkg::NOP;
    last_act_ba   = '0;
    last_col_ap   = 1'b0;
    last_col_wr   = 1'b0;
    for (int i = 0; i < num_banks_lp; i++) begin
      open_bank[i] = 1'b0;
      open_row[i]  = '0;
    end

    // power-up sequence
    expect_cmd(dmc_pkg::PRE, '0, pre_all_addr_lp, 1'b0, 1'b1, "power-up PRE-all");
    expect_cmd(dmc_pkg::REF, '0, '0, 1'b0, 1'b0, "power-up REF");
    expect_cmd(dmc_pkg::REF, '0, '0, 1'b0, 1'b0, "power-up REF");
    expect_cmd(dmc_pkg::LMR, 'd0, `DMC_MR0, 1'b1, 1'b1, "power-up LMR");
    expect_cmd(dmc_pkg::LMR, 'd2, '0, 1'b1, 1'b0, "power-up extended LMR");

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    waited = 0;
    @(negedge clk);
    while (!init_done) begin
      waited++;
      if (waited > wait_limit_lp) begin
        $display("init_calib_complete_o never rose");
        end_with_failure();
      end
      @(negedge clk);
    end
    @(posedge clk);

    for (int n = 0; n < num_req_lp; n++) begin
      idle = 0;
      if (take_bits(2) == 0) idle = int'(take_bits(3));  // mostly back-to-back bursts
      if (idle != 0) begin
        app_en <= 1'b0;
        repeat (idle) @(posedge clk);
      end
      cmd  = dmc_pkg::app_cmd_e'(3'(take_bits(2)));
      addr = '0;
      addr[`DMC_COL_POS +: `DMC_COL_WIDTH]   = `DMC_COL_WIDTH'(take_bits(`DMC_COL_WIDTH));
      addr[`DMC_BANK_POS +: `DMC_BANK_WIDTH] = `DMC_BANK_WIDTH'(take_bits(2));
      addr[`DMC_ROW_POS +: `DMC_ROW_WIDTH]   = `DMC_ROW_WIDTH'(take_bits(2));
      app_en   <= 1'b1;
      app_cmd  <= cmd;
      app_addr <= addr;
      waited = 0;
      @(negedge clk);
      while (!app_rdy) begin
        waited++;
        if (waited > wait_limit_lp) begin
          $display("request %0d was never accepted", n);
          end_with_failure();
        end
        @(negedge clk);
      end
      @(posedge clk);
    end
    app_en <= 1'b0;

    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > wait_limit_lp) begin
        $display("%0d expected commands never appeared on the pins", exp_q.size());
        end_with_failure();
      end
    end

    if (refresh_count == 0) begin
      $display("no refresh was seen during the run");
      end_with_failure();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: logic/dmc_cmd_queue.sv
`timescale 1ns/10ps
`include "dmc_settings.svh"

module dmc_cmd_queue (
  input logic    dfi_clk_i,
  input logic    dfi_clk_sync_rst_i,
  dfi_cmd_if.dst enq_if,
  dfi_cmd_if.src deq_if
);

  localparam int depth_lp = `DMC_QUEUE_DEPTH;
  localparam int ptr_w_lp = $clog2(depth_lp);

  dmc_pkg::dfi_cmd_entry_s mem_q [depth_lp];
  logic [ptr_w_lp-1:0]     wptr_q, rptr_q;
  logic [ptr_w_lp:0]       count_q;
  logic                    push;
  logic                    pop;

  assign enq_if.ready = (count_q != depth_lp);
  assign deq_if.valid = (count_q != '0) & deq_if.ready;  // head is offered only once ready
  assign deq_if.entry = mem_q[rptr_q];

  assign push = enq_if.valid & enq_if.ready;
  assign pop  = deq_if.valid & deq_if.ready;

  always_ff @(posedge dfi_clk_i) begin
    if (push) mem_q[wptr_q] <= enq_if.entry;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) wptr_q <= (wptr_q == ptr_w_lp'(depth_lp - 1)) ? '0 : wptr_q + 1'b1;
      if (pop)  rptr_q <= (rptr_q == ptr_w_lp'(depth_lp - 1)) ? '0 : rptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: logic/dmc_top.sv
`timescale 1ns/10ps
`include "dmc_settings.svh"

module dmc_top (
  input  logic                           dfi_clk_i,
  input  logic                           dfi_clk_sync_rst_i,
  input  logic                           app_en_i,
  input  dmc_pkg::app_cmd_e              app_cmd_i,
  input  logic [`DMC_ADDR_WIDTH-1:0]     app_addr_i,
  output logic                           app_rdy_o,
  output logic                           init_calib_complete_o,
  output logic                           refresh_in_progress_o,
  output logic                           dfi_cke_o,
  output logic                           dfi_cs_n_o,
  output logic                           dfi_ras_n_o,
  output logic                           dfi_cas_n_o,
  output logic                           dfi_we_n_o,
  output logic [`DMC_BANK_WIDTH-1:0]     dfi_bank_o,
  output logic [`DMC_DFI_ADDR_WIDTH-1:0] dfi_address_o
);

  dfi_cmd_if enq_if ();  // sequencer to queue
  dfi_cmd_if deq_if ();  // queue to scheduler

  dmc_cmd_sequencer u_sequencer (
    .dfi_clk_i             (dfi_clk_i),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst_i),
    .app_en_i              (app_en_i),
    .app_cmd_i             (app_cmd_i),
    .app_addr_i            (app_addr_i),
    .app_rdy_o             (app_rdy_o),
    .init_calib_complete_o (init_calib_complete_o),
    .refresh_in_progress_o (refresh_in_progress_o),
    .enq_if                (enq_if.src)
  );

  dmc_cmd_queue u_queue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .enq_if             (enq_if.dst),
    .deq_if             (deq_if.src)
  );

  dmc_issue_scheduler u_scheduler (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .deq_if             (deq_if.dst),
    .dfi_cke_o          (dfi_cke_o),
    .dfi_cs_n_o         (dfi_cs_n_o),
    .dfi_ras_n_o        (dfi_ras_n_o),
    .dfi_cas_n_o        (dfi_cas_n_o),
    .dfi_we_n_o         (dfi_we_n_o),
    .dfi_bank_o         (dfi_bank_o),
    .dfi_address_o      (dfi_address_o)
  );

endmodule

// File: scheduler/dmc_issue_scheduler.sv
`timescale 1ns/10ps
`include "dmc_settings.svh"

module dmc_issue_scheduler (
  input  logic                           dfi_clk_i,
  input  logic                           dfi_clk_sync_rst_i,
  dfi_cmd_if.dst                         deq_if,
  output logic                           dfi_cke_o,
  output logic                           dfi_cs_n_o,
  output logic                           dfi_ras_n_o,
  output logic                           dfi_cas_n_o,
  output logic                           dfi_we_n_o,
  output logic [`DMC_BANK_WIDTH-1:0]     dfi_bank_o,
  output logic [`DMC_DFI_ADDR_WIDTH-1:0] dfi_address_o
);

  localparam int tick_w_lp = `DMC_TICK_WIDTH;

  // one saturating counter per kind of last command
  logic [3:0][tick_w_lp-1:0]  tick_q;
  logic [3:0]                 tick_clr;
  logic [tick_w_lp-1:0]       cmd_tick, act_tick, wr_tick, rd_tick;

  dmc_pkg::dfi_cmd_e          next_op, last_op_q;
  logic [`DMC_BANK_WIDTH-1:0] next_ba, last_act_ba_q;
  logic                       last_col_ap_q;
  logic                       last_col_wr_q;
  logic                       last_ok, next_ok;
  logic                       ap_ok, col_ok;
  logic                       pop;

  assign next_op = deq_if.entry.cmd.op;
  assign next_ba = deq_if.entry.ba;

  assign cmd_tick = tick_q[0];
  assign act_tick = tick_q[1];
  assign wr_tick  = tick_q[2];
  assign rd_tick  = tick_q[3];

  assign deq_if.ready = last_ok & next_ok;  // depends on the head only, never on valid
  assign pop          = deq_if.valid & deq_if.ready;

  assign tick_clr = {pop & (next_op == dmc_pkg::READ),
                     pop & (next_op == dmc_pkg::WRITE),
                     pop & (next_op == dmc_pkg::ACT),
                     pop};

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      tick_q <= '1;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (tick_clr[i])          tick_q[i] <= '0;
        else if (tick_q[i] != '1) tick_q[i] <= tick_q[i] + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // spacing rules

  // an internal precharge after an auto-precharge column must finish first
  assign ap_ok  = !last_col_ap_q ||
                  (last_col_wr_q ? (wr_tick >= `DMC_TWR + `DMC_TRP)
                                 : (rd_tick >= `DMC_TRTP + `DMC_TRP));
  assign col_ok = (wr_tick >= `DMC_BURST_CYCLES) && (rd_tick >= `DMC_BURST_CYCLES);

  always_comb begin
    case (last_op_q)
      dmc_pkg::LMR: last_ok = (cmd_tick >= `DMC_TMRD);
      dmc_pkg::REF: last_ok = (cmd_tick >= `DMC_TRFC);
      dmc_pkg::PRE: last_ok = (cmd_tick >= `DMC_TRP);
      default:      last_ok = 1'b1;
    endcase

    case (next_op)
      dmc_pkg::PRE: begin
        next_ok = (act_tick >= `DMC_TRAS) && (wr_tick >= `DMC_TWR) && (rd_tick >= `DMC_TRTP);
      end
      dmc_pkg::ACT: begin
        // a second ACT to the same bank means a new row there
        next_ok = ap_ok && (act_tick >= `DMC_TRRD) &&
                  ((act_tick >= `DMC_TRC) || (next_ba != last_act_ba_q));
      end
      dmc_pkg::REF:   next_ok = ap_ok;
      dmc_pkg::WRITE: begin
        next_ok = (act_tick >= `DMC_TRCD) && col_ok &&
                  (rd_tick >= `DMC_TCAS + `DMC_BURST_CYCLES);
      end
      dmc_pkg::READ:  next_ok = (act_tick >= `DMC_TRCD) && col_ok && (wr_tick >= `DMC_TWTR);
      default:        next_ok = 1'b1;
    endcase
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      last_op_q     <= dmc_pkg::NOP;
      last_col_ap_q <= 1'b0;
      last_col_wr_q <= 1'b0;
    end else if (pop) begin
      last_op_q <= next_op;
      if (next_op == dmc_pkg::READ || next_op == dmc_pkg::WRITE) begin
        last_col_ap_q <= deq_if.entry.addr[`DMC_AP_BIT];
        last_col_wr_q <= (next_op == dmc_pkg::WRITE);
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (pop && next_op == dmc_pkg::ACT) last_act_ba_q <= next_ba;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DFI command outputs

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      dfi_cke_o <= 1'b0;
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= dmc_pkg::DESELECT;
    end else begin
      dfi_cke_o <= 1'b1;
      if (pop) {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= deq_if.entry.cmd.pins;
      else     {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= dmc_pkg::DESELECT;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (pop) begin
      dfi_bank_o    <= deq_if.entry.ba;
      dfi_address_o <= deq_if.entry.addr;
    end
  end

endmodule

// File: sequencer/dmc_cmd_sequencer.sv
`timescale 1ns/10ps
`include "dmc_settings.svh"

module dmc_cmd_sequencer (
  input  logic                       dfi_clk_i,
  input  logic                       dfi_clk_sync_rst_i,
  input  logic                       app_en_i,
  input  dmc_pkg::app_cmd_e          app_cmd_i,
  input  logic [`DMC_ADDR_WIDTH-1:0] app_addr_i,
  output logic                       app_rdy_o,
  output logic                       init_calib_complete_o,
  output logic                       refresh_in_progress_o,
  dfi_cmd_if.src                     enq_if
);

  localparam int num_banks_lp = 1 << `DMC_BANK_WIDTH;
  localparam int step_w_lp    = $clog2(`DMC_INIT_CMDS);

  typedef enum logic [1:0] {IDLE, INIT, REFR, LDST} state_e;

  state_e                     state_q, state_d;
  logic                       push;
  logic                       accept;
  logic                       init_done_q;
  logic [step_w_lp-1:0]       step_q;       // entries still to push in this state, minus one
  logic [`DMC_REFI_WIDTH-1:0] refi_cnt_q;
  logic                       refr_req_q;
  logic                       refr_ack;

  logic [`DMC_COL_WIDTH-1:0]  app_col, req_col_q;
  logic [`DMC_BANK_WIDTH-1:0] app_bank, req_bank_q;
  logic [`DMC_ROW_WIDTH-1:0]  app_row, req_row_q;
  logic                       req_rd_q;
  logic                       req_ap_q;
  logic                       app_open;
  logic                       app_hit;

  logic [num_banks_lp-1:0]    open_bank_q;
  logic [`DMC_ROW_WIDTH-1:0]  open_row_q [num_banks_lp];

  dmc_pkg::dfi_cmd_entry_s    entry;

  assign app_col  = app_addr_i[`DMC_COL_POS +: `DMC_COL_WIDTH];
  assign app_bank = app_addr_i[`DMC_BANK_POS +: `DMC_BANK_WIDTH];
  assign app_row  = app_addr_i[`DMC_ROW_POS +: `DMC_ROW_WIDTH];

  assign app_open = open_bank_q[app_bank];
  assign app_hit  = app_open && (open_row_q[app_bank] == app_row);

  assign app_rdy_o = (state_q == IDLE) & init_done_q & ~refr_req_q;
  assign accept    = app_en_i & app_rdy_o;
  assign push      = (state_q != IDLE) & enq_if.ready;  // valid only follows ready

  assign enq_if.valid = push;
  assign enq_if.entry = entry;

  assign init_calib_complete_o = init_done_q;
  assign refresh_in_progress_o = (state_q == REFR);
  assign refr_ack = (state_q == REFR) & push & (step_q == '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine and step counter

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (!init_done_q)    state_d = INIT;
        else if (refr_req_q) state_d = REFR;
        else if (accept)     state_d = LDST;
      end
      default: if (push && step_q == '0) state_d = IDLE;
    endcase
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      state_q     <= IDLE;
      step_q      <= '0;
      init_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        if (state_d == INIT)      step_q <= step_w_lp'(`DMC_INIT_CMDS - 1);
        else if (state_d == REFR) step_q <= step_w_lp'(|open_bank_q);  // PRE-all first
        else if (state_d == LDST) step_q <= app_hit ? 'd0 : (app_open ? 'd2 : 'd1);
      end else if (push && step_q != '0) begin
        step_q <= step_q - 1'b1;
      end
      if (state_q == INIT && push && step_q == '0) init_done_q <= 1'b1;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (accept) begin
      req_col_q  <= app_col;
      req_bank_q <= app_bank;
      req_row_q  <= app_row;
      req_rd_q   <= app_cmd_i[0];
      req_ap_q   <= app_cmd_i[1];
    end
  end

  // the interval keeps running while a request waits for its REF
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      refi_cnt_q <= '0;
      refr_req_q <= 1'b0;
    end else if (init_done_q) begin
      if (refi_cnt_q == `DMC_TREFI) begin
        refi_cnt_q <= '0;
        refr_req_q <= 1'b1;
      end else begin
        refi_cnt_q <= refi_cnt_q + 1'b1;
        if (refr_ack) refr_req_q <= 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // entry for the current step

  always_comb begin
    entry = '0;
    entry.cmd.op = dmc_pkg::DESELECT;
    case (state_q)
      INIT: begin
        case (step_q)
          'd4: begin
            entry.cmd.op = dmc_pkg::PRE;
            entry.addr[`DMC_AP_BIT] = 1'b1;
          end
          'd3, 'd2: entry.cmd.op = dmc_pkg::REF;
          'd1: begin
            entry.cmd.op = dmc_pkg::LMR;
            entry.addr   = `DMC_MR0;
          end
          default: begin
            entry.cmd.op = dmc_pkg::LMR;  // extended mode register, all defaults
            entry.ba     = 'd2;
          end
        endcase
      end
      REFR: begin
        if (step_q != '0) begin
          entry.cmd.op = dmc_pkg::PRE;
          entry.addr[`DMC_AP_BIT] = 1'b1;
        end else begin
          entry.cmd.op = dmc_pkg::REF;
        end
      end
      LDST: begin
        entry.ba = req_bank_q;
        case (step_q)
          'd2: entry.cmd.op = dmc_pkg::PRE;  // A10 low closes this bank only
          'd1: begin
            entry.cmd.op = dmc_pkg::ACT;
            entry.addr[`DMC_ROW_WIDTH-1:0] = req_row_q;
          end
          default: begin
            entry.cmd.op = req_rd_q ? dmc_pkg::READ : dmc_pkg::WRITE;
            entry.addr[`DMC_COL_WIDTH-1:0] = req_col_q;
            entry.addr[`DMC_AP_BIT] = req_ap_q;
          end
        endcase
      end
      default: ;
    endcase
  end

  // open-row table follows every pushed entry
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      open_bank_q <= '0;
    end else if (push) begin
      case (entry.cmd.op)
        dmc_pkg::ACT: open_bank_q[entry.ba] <= 1'b1;
        dmc_pkg::PRE: begin
          if (entry.addr[`DMC_AP_BIT]) open_bank_q <= '0;
          else                         open_bank_q[entry.ba] <= 1'b0;
        end
        dmc_pkg::READ, dmc_pkg::WRITE: begin
          if (entry.addr[`DMC_AP_BIT]) open_bank_q[entry.ba] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (push && entry.cmd.op == dmc_pkg::ACT) begin
      open_row_q[entry.ba] <= entry.addr[`DMC_ROW_WIDTH-1:0];
    end
  end

endmodule
